/* all.f */
+incdir+hw
+incdir+tests
hw/dispatcher_pkg.sv
hw/cpu_scheduler.sv
hw/mem_bridge.sv
hw/dispatch_ctl.sv
hw/dispatcher_top.sv
tests/dispatcher_tb.sv

/* hw/cpu_scheduler.sv */
`timescale 1ns/1ps
`include "dispatcher_params.svh"

module cpu_scheduler
  import dispatcher_pkg::*;
(
  input  logic     clk,
  input  logic     ext_rst_e,
  input  logic     sel_next,
  input  logic     event_valid,
  input  cpu_msg_t cpu_event,
  output cpu_sel_u ext_cpu_index
);

  // counts share the width of a CPU number plus one
  localparam int CNT_W = `CPU_NUM_W + 1;

  logic [CNT_W-1:0]      act_cnt;
  logic [CNT_W-1:0]      inact_cnt;
  logic [`CPU_NUM_W-1:0] cpu_num;
  logic [`CPU_NUM_W-1:0] next_num;
  logic [CNT_W-1:0]      num_inc;
  logic                  na_last;
  logic                  pick_na;
  logic                  wrap;
  cpu_sel_u              sel_d;
  cpu_sel_u              sel_q;

  // last polled number plus one, extended to count width
  assign num_inc = {1'b0, cpu_num} + 1'b1;

  // wrap once the last active slot was polled
  assign wrap     = (num_inc >= act_cnt);
  assign next_num = wrap ? '0 : num_inc[`CPU_NUM_W-1:0];

  // inactive poll every other turn while any CPU sleeps
  // nothing else to poll with no active CPU
  assign pick_na = (act_cnt == '0) || ((inact_cnt != '0) && !na_last);

  always_comb begin
    sel_d = '0;
    if (pick_na) begin
      // broadcast code through the raw view
      sel_d.raw = `CPU_NONACTIVE;
    end else begin
      sel_d.slot.active = 1'b1;
      sel_d.slot.num    = next_num;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      act_cnt   <= '0;
      inact_cnt <= CNT_W'(`CPU_QUANTITY);
      cpu_num   <= '0;
      na_last   <= 1'b0;
      sel_q     <= '0;
    end else begin
      // index moves only when a poll is about to start
      if (sel_next) begin
        sel_q   <= sel_d;
        na_last <= pick_na;
        if (!pick_na) begin
          cpu_num <= next_num;
        end
      end
      // CPU moves between pools
      if (event_valid) begin
        case (cpu_event)
          MSG_START: begin
            if (inact_cnt != '0) begin
              act_cnt   <= act_cnt + 1'b1;
              inact_cnt <= inact_cnt - 1'b1;
            end
          end
          MSG_END: begin
            if (act_cnt != '0) begin
              act_cnt   <= act_cnt - 1'b1;
              inact_cnt <= inact_cnt + 1'b1;
            end
          end
          default: begin
            // nothing to count
          end
        endcase
      end
    end
  end

  assign ext_cpu_index = sel_q;

  // pool size is fixed, CPUs only change sides
  a_pool_total: assert property (@(posedge clk) disable iff (ext_rst_e)
    (act_cnt + inact_cnt) == CNT_W'(`CPU_QUANTITY));

endmodule

/* hw/dispatch_ctl.sv */
`timescale 1ns/1ps
`include "dispatcher_params.svh"

module dispatch_ctl
  import dispatcher_pkg::*;
(
  input  logic     clk,
  input  logic     ext_rst_e,
  input  logic     ext_cpu_e,
  input  logic     ext_bus_q,
  input  logic     mem_busy,
  input  cpu_msg_t cpu_msg_in,
  input  cpu_req_t cpu_req,
  output logic     ext_cpu_q,
  output logic     ext_bus_allow,
  output logic     bus_busy,
  output logic     sel_next,
  output logic     event_valid,
  output logic     mem_start,
  output cpu_msg_t cpu_event
);

  typedef enum logic [2:0] {
    ST_LOOP,
    ST_POLL,
    ST_RELEASE,
    ST_MEM,
    ST_BUS
  } ctl_state_t;

  localparam int PT_W = $clog2(`POLL_TIMEOUT + 1);

  ctl_state_t      state;
  logic [PT_W-1:0] poll_cnt;
  logic            can_poll;
  logic            answered;
  logic            has_mem;
  logic            poll_tmo;

  // CPU answer while our poll is up
  assign answered = (state == ST_POLL) && ext_cpu_e;
  assign has_mem  = cpu_req.read_q || cpu_req.write_q;

  // last silent cycle of a poll
  assign poll_tmo = (poll_cnt == PT_W'(`POLL_TIMEOUT - 1));

  // idle loop, no bus request, previous answer gone
  assign can_poll = (state == ST_LOOP) && !ext_bus_q && !ext_cpu_e &&
                    !mem_busy && !ext_bus_allow;

  // scheduler steps together with the poll start
  assign sel_next = can_poll;

  // answer goes either to memory or to the scheduler
  assign mem_start   = answered && has_mem;
  assign event_valid = answered && !has_mem;
  assign cpu_event   = cpu_msg_in;

  assign bus_busy = (state == ST_MEM) || (state == ST_BUS);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= ST_LOOP;
      poll_cnt      <= '0;
      ext_cpu_q     <= 1'b0;
      ext_bus_allow <= 1'b0;
    end else begin
      case (state)
        ST_LOOP: begin
          poll_cnt <= '0;
          // external master first
          if (ext_bus_q && !mem_busy) begin
            state <= ST_BUS;
          end else if (can_poll) begin
            ext_cpu_q <= 1'b1;
            state     <= ST_POLL;
          end
        end
        ST_POLL: begin
          if (ext_cpu_e) begin
            ext_cpu_q <= 1'b0;
            // memory op keeps the bus until the bridge is done
            state     <= has_mem ? ST_MEM : ST_RELEASE;
          end else if (poll_tmo) begin
            // silent CPU, move on
            ext_cpu_q <= 1'b0;
            state     <= ST_LOOP;
          end else begin
            poll_cnt <= poll_cnt + 1'b1;
          end
        end
        ST_RELEASE: begin
          // wait for ext_cpu_e to drop
          if (!ext_cpu_e) begin
            state <= ST_LOOP;
          end
        end
        ST_MEM: begin
          // both the bridge and the poll answer must close
          if (!mem_busy && !ext_cpu_e) begin
            state <= ST_LOOP;
          end
        end
        ST_BUS: begin
          if (ext_bus_q) begin
            ext_bus_allow <= 1'b1;
          end else begin
            ext_bus_allow <= 1'b0;
            state         <= ST_LOOP;
          end
        end
        default: state <= ST_LOOP;
      endcase
    end
  end

  // bus grant and poll exclude each other
  a_poll_vs_bus: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_cpu_q && ext_bus_allow));

  // bridge takes the op right after the start pulse
  a_mem_taken: assert property (@(posedge clk) disable iff (ext_rst_e)
    mem_start |=> (bus_busy && mem_busy));

endmodule

/* hw/dispatcher_params.svh */
`ifndef DISPATCHER_PARAMS_SVH
`define DISPATCHER_PARAMS_SVH

// number of CPUs in the pool
`define CPU_QUANTITY 8

// bus widths
`define ADDR_W 32
`define DATA_W 32

// width of a CPU number inside the select code
`define CPU_NUM_W 7

// cycles a memory request may wait for its done
`define MEM_TIMEOUT 50

// cycles a poll may wait for the CPU to answer
`define POLL_TIMEOUT 16

// raw select code that wakes any inactive CPU
`define CPU_NONACTIVE 8'h7F

`endif

/* hw/dispatcher_pkg.sv */
`include "dispatcher_params.svh"

package dispatcher_pkg;

  // messages a CPU reports in its poll answer
  typedef enum logic [2:0] {
    MSG_NONE  = 3'd0,
    MSG_START = 3'd1,
    MSG_END   = 3'd2
  } cpu_msg_t;

  // slot view: active flag on top, CPU number below
  typedef struct packed {
    logic                  active;
    logic [`CPU_NUM_W-1:0] num;
  } cpu_slot_t;

  // same 8 bits seen as slot or as raw code
  typedef union packed {
    cpu_slot_t  slot;
    logic [7:0] raw;
  } cpu_sel_u;

  // CPU to dispatcher, valid during a poll answer
  typedef struct packed {
    logic               read_q;
    logic               write_q;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } cpu_req_t;

  // dispatcher back to the CPU
  typedef struct packed {
    logic               read_dn;
    logic               write_dn;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } cpu_rsp_t;

  // dispatcher to external memory
  typedef struct packed {
    logic               read_q;
    logic               write_q;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } mem_req_t;

  // external memory answer
  typedef struct packed {
    logic               read_dn;
    logic               write_dn;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } mem_rsp_t;

endpackage

/* hw/dispatcher_top.sv */
`timescale 1ns/1ps
`include "dispatcher_params.svh"

module dispatcher_top
  import dispatcher_pkg::*;
(
  input  logic     clk,
  input  logic     ext_rst_e,
  // CPU side
  output logic     ext_cpu_q,
  output cpu_sel_u ext_cpu_index,
  input  logic     ext_cpu_e,
  input  cpu_msg_t cpu_msg_in,
  input  cpu_req_t cpu_req,
  output cpu_rsp_t cpu_rsp,
  output logic     rw_halt_out,
  // memory side
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     ext_rw_halt_out,
  // external master
  input  logic     ext_bus_q,
  output logic     ext_bus_allow,
  output logic     bus_busy
);

  logic     sel_next;
  logic     event_valid;
  logic     mem_start;
  logic     mem_busy;
  cpu_msg_t cpu_event;

  // poll order and pool accounting
  cpu_scheduler sched_i (
    .clk          (clk),
    .ext_rst_e    (ext_rst_e),
    .sel_next     (sel_next),
    .event_valid  (event_valid),
    .cpu_event    (cpu_event),
    .ext_cpu_index(ext_cpu_index)
  );

  // CPU to memory path
  mem_bridge bridge_i (
    .clk            (clk),
    .ext_rst_e      (ext_rst_e),
    .mem_start      (mem_start),
    .cpu_req        (cpu_req),
    .cpu_rsp        (cpu_rsp),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp),
    .mem_busy       (mem_busy),
    .rw_halt_out    (rw_halt_out),
    .ext_rw_halt_out(ext_rw_halt_out)
  );

  // main FSM
  dispatch_ctl ctl_i (
    .clk          (clk),
    .ext_rst_e    (ext_rst_e),
    .ext_cpu_e    (ext_cpu_e),
    .ext_bus_q    (ext_bus_q),
    .mem_busy     (mem_busy),
    .cpu_msg_in   (cpu_msg_in),
    .cpu_req      (cpu_req),
    .ext_cpu_q    (ext_cpu_q),
    .ext_bus_allow(ext_bus_allow),
    .bus_busy     (bus_busy),
    .sel_next     (sel_next),
    .event_valid  (event_valid),
    .mem_start    (mem_start),
    .cpu_event    (cpu_event)
  );

endmodule

/* hw/mem_bridge.sv */
`timescale 1ns/1ps
`include "dispatcher_params.svh"

module mem_bridge
  import dispatcher_pkg::*;
(
  input  logic     clk,
  input  logic     ext_rst_e,
  input  logic     mem_start,
  input  cpu_req_t cpu_req,
  output cpu_rsp_t cpu_rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     mem_busy,
  output logic     rw_halt_out,
  output logic     ext_rw_halt_out
);

  // memory request, memory release, CPU done
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MREQ,
    ST_MREL,
    ST_CDONE
  } br_state_t;

  localparam int TMO_W = $clog2(`MEM_TIMEOUT + 1);

  br_state_t          state;
  logic [TMO_W-1:0]   tmo_cnt;
  logic               rd_q;
  logic               wr_q;
  logic               rd_dn;
  logic               wr_dn;
  logic               op_wr;
  logic               halt_r;
  logic               wr_sel;
  logic               mem_done;
  logic               cpu_drop;
  logic [`ADDR_W-1:0] req_addr;
  logic [`DATA_W-1:0] req_data;
  logic [`ADDR_W-1:0] rsp_addr;
  logic [`DATA_W-1:0] rsp_data;

  // read wins if the CPU raises both
  assign wr_sel = !cpu_req.read_q;

  // done matching the request in flight
  assign mem_done = (rd_q && mem_rsp.read_dn) || (wr_q && mem_rsp.write_dn);

  // CPU closed its side of the exchange
  assign cpu_drop = op_wr ? !cpu_req.write_q : !cpu_req.read_q;

  // address and data holding
  always_ff @(posedge clk) begin
    if (mem_start && state == ST_IDLE) begin
      op_wr    <= wr_sel;
      req_addr <= cpu_req.addr;
      req_data <= wr_sel ? cpu_req.data : '0;
    end
    // memory answer held for the CPU
    if (state == ST_MREQ && mem_done) begin
      rsp_addr <= mem_rsp.addr;
      rsp_data <= mem_rsp.data;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state   <= ST_IDLE;
      tmo_cnt <= '0;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
      rd_dn   <= 1'b0;
      wr_dn   <= 1'b0;
      halt_r  <= 1'b0;
    end else begin
      // halt is a single pulse
      halt_r <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (mem_start) begin
            rd_q    <= !wr_sel;
            wr_q    <= wr_sel;
            tmo_cnt <= '0;
            state   <= ST_MREQ;
          end
        end
        ST_MREQ: begin
          if (mem_done) begin
            rd_q  <= 1'b0;
            wr_q  <= 1'b0;
            state <= ST_MREL;
          end else if (tmo_cnt == TMO_W'(`MEM_TIMEOUT)) begin
            // memory gave no answer so the op is dropped
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
            halt_r <= 1'b1;
            state  <= ST_IDLE;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        ST_MREL: begin
          // memory drops its done before the CPU sees one
          if (!mem_rsp.read_dn && !mem_rsp.write_dn) begin
            rd_dn <= !op_wr;
            wr_dn <= op_wr;
            state <= ST_CDONE;
          end
        end
        ST_CDONE: begin
          if (cpu_drop) begin
            rd_dn <= 1'b0;
            wr_dn <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign mem_req = '{read_q: rd_q, write_q: wr_q, addr: req_addr, data: req_data};
  assign cpu_rsp = '{read_dn: rd_dn, write_dn: wr_dn, addr: rsp_addr, data: rsp_data};

  // busy from the start pulse on
  assign mem_busy = mem_start || (state != ST_IDLE);

  // timeout halts both sides
  assign rw_halt_out     = halt_r;
  assign ext_rw_halt_out = halt_r;

  // CPU asks for one direction at a time
  a_rw_excl: assert property (@(posedge clk) disable iff (ext_rst_e)
    mem_start |-> !(cpu_req.read_q && cpu_req.write_q));

  // done to the CPU only while it still asks
  a_cpu_rd_dn: assert property (@(posedge clk) disable iff (ext_rst_e)
    $rose(cpu_rsp.read_dn) |-> cpu_req.read_q);
  a_cpu_wr_dn: assert property (@(posedge clk) disable iff (ext_rst_e)
    $rose(cpu_rsp.write_dn) |-> cpu_req.write_q);

  // memory must not answer a request it never got
  a_mem_dn: assert property (@(posedge clk) disable iff (ext_rst_e)
    ($rose(mem_rsp.read_dn) |-> mem_req.read_q) and
    ($rose(mem_rsp.write_dn) |-> mem_req.write_q));

endmodule

/* tests/dispatcher_checks.svh */
`ifndef DISPATCHER_CHECKS_SVH
`define DISPATCHER_CHECKS_SVH

// poll index against the scheduler model
task automatic check_sel(input string name, input cpu_sel_u got, input cpu_sel_u exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// response seen by the CPU
task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// request seen by the memory
task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// waits sample on the falling edge between drive edges
task automatic wait_cpu_q(input logic level);
  int n;
  n = 0;
  @(negedge clk);
  while (ext_cpu_q !== level) begin
    if (n == WAIT_LIMIT) begin
      abort_run($sformatf("ext_cpu_q never went to %0b within %0d cycles", level, n));
    end
    n++;
    @(negedge clk);
  end
endtask

// no poll may start while the grant is pending or held
task automatic wait_bus_allow(input logic level);
  int n;
  n = 0;
  @(negedge clk);
  while (ext_bus_allow !== level) begin
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    if (n == WAIT_LIMIT) begin
      abort_run($sformatf("ext_bus_allow never went to %0b within %0d cycles", level, n));
    end
    n++;
    @(negedge clk);
  end
endtask

// either request bit towards memory
task automatic wait_mem_req(input logic level);
  int n;
  n = 0;
  @(negedge clk);
  while ((mem_req.read_q || mem_req.write_q) !== level) begin
    if (n == WAIT_LIMIT) begin
      abort_run($sformatf("memory request never went to %0b within %0d cycles", level, n));
    end
    n++;
    @(negedge clk);
  end
endtask

// either done bit towards the CPU
task automatic wait_cpu_done(input logic level);
  int n;
  n = 0;
  @(negedge clk);
  while ((cpu_rsp.read_dn || cpu_rsp.write_dn) !== level) begin
    if (n == WAIT_LIMIT) begin
      abort_run($sformatf("CPU done never went to %0b within %0d cycles", level, n));
    end
    n++;
    @(negedge clk);
  end
endtask

`endif

/* tests/dispatcher_tb.sv */
`timescale 1ns/1ps
`include "dispatcher_params.svh"

module dispatcher_tb
  import dispatcher_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic     clk;
  logic     ext_rst_e;
  logic     ext_cpu_q;
  cpu_sel_u ext_cpu_index;
  logic     ext_cpu_e;
  cpu_msg_t cpu_msg_in;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  logic     rw_halt_out;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     ext_rw_halt_out;
  logic     ext_bus_q;
  logic     ext_bus_allow;
  logic     bus_busy;

  integer seed;
  // scheduler model: counts, round-robin number, inactive flag
  int   m_act;
  int   m_inact;
  int   m_num;
  logic m_na;
  // memory model, indexed by low address bits
  logic [`DATA_W-1:0] mem_store [0:255];

  dispatcher_top dut_i (
    .clk            (clk),
    .ext_rst_e      (ext_rst_e),
    .ext_cpu_q      (ext_cpu_q),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_e      (ext_cpu_e),
    .cpu_msg_in     (cpu_msg_in),
    .cpu_req        (cpu_req),
    .cpu_rsp        (cpu_rsp),
    .rw_halt_out    (rw_halt_out),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp),
    .ext_rw_halt_out(ext_rw_halt_out),
    .ext_bus_q      (ext_bus_q),
    .ext_bus_allow  (ext_bus_allow),
    .bus_busy       (bus_busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "dispatcher_checks.svh"

  // inactive poll due next
  function automatic logic na_next();
    return (m_act == 0) || ((m_inact != 0) && !m_na);
  endfunction

  // predicted index of the next poll, model steps with it
  task automatic next_index(output cpu_sel_u exp);
    exp = '0;
    if (na_next()) begin
      exp.raw = `CPU_NONACTIVE;
      m_na    = 1'b1;
    end else begin
      // wrap after the last active number
      m_num = (m_num + 1 >= m_act) ? 0 : m_num + 1;
      exp.slot.active = 1'b1;
      exp.slot.num    = m_num[`CPU_NUM_W-1:0];
      m_na            = 1'b0;
    end
  endtask

  task automatic count_msg(input cpu_msg_t msg);
    if (msg == MSG_START && m_inact > 0) begin
      m_act++;
      m_inact--;
    end else if (msg == MSG_END && m_act > 0) begin
      m_act--;
      m_inact++;
    end
  endtask

  // CPU side: take the poll and raise the answer
  task automatic start_answer(input cpu_msg_t msg, input cpu_req_t req);
    cpu_sel_u exp_sel;
    wait_cpu_q(1'b1);
    next_index(exp_sel);
    check_sel("ext_cpu_index", ext_cpu_index, exp_sel);
    @(posedge clk);
    ext_cpu_e  <= 1'b1;
    cpu_msg_in <= msg;
    cpu_req    <= req;
    // memory answers carry no message for the pool
    if (!(req.read_q || req.write_q)) begin
      count_msg(msg);
    end
  endtask

  task automatic finish_answer();
    wait_cpu_q(1'b0);
    @(posedge clk);
    ext_cpu_e  <= 1'b0;
    cpu_msg_in <= MSG_NONE;
  endtask

  task automatic answer_poll(input cpu_msg_t msg);
    start_answer(msg, '0);
    finish_answer();
  endtask

  // one CPU op through the bridge, memory model answers after a random delay
  task automatic mem_exchange(input logic is_write, input logic [`ADDR_W-1:0] addr,
                              input logic [`DATA_W-1:0] data);
    cpu_req_t           req;
    mem_req_t           exp_mreq;
    cpu_rsp_t           exp_rsp;
    int                 delay;
    logic [`DATA_W-1:0] rdata;
    req         = '0;
    req.read_q  = !is_write;
    req.write_q = is_write;
    req.addr    = addr;
    req.data    = is_write ? data : '0;
    start_answer(MSG_NONE, req);
    wait_mem_req(1'b1);
    // reads go out with zero data
    exp_mreq = '{read_q: !is_write, write_q: is_write, addr: addr,
                 data: (is_write ? data : '0)};
    check_mem_req("mem_req", mem_req, exp_mreq);
    check_bit("bus_busy", bus_busy, 1'b1);
    @(posedge clk);
    ext_cpu_e <= 1'b0;
    delay = 1 + ($unsigned($random(seed)) % 8);
    repeat (delay) @(posedge clk);
    if (is_write) begin
      mem_store[mem_req.addr[7:0]] = mem_req.data;
    end
    rdata = mem_store[mem_req.addr[7:0]];
    mem_rsp <= '{read_dn: !is_write, write_dn: is_write, addr: mem_req.addr, data: rdata};
    // memory four-phase close
    wait_mem_req(1'b0);
    @(posedge clk);
    mem_rsp <= '0;
    wait_cpu_done(1'b1);
    exp_rsp = '{read_dn: !is_write, write_dn: is_write, addr: addr, data: data};
    check_rsp("cpu_rsp", cpu_rsp, exp_rsp);
    check_bit("bus_busy", bus_busy, 1'b1);
    @(posedge clk);
    cpu_req <= '0;
    wait_cpu_done(1'b0);
  endtask

  task automatic test_reset_values();
    cpu_sel_u na_code;
    repeat (4) @(posedge clk);
    ext_rst_e <= 1'b0;
    @(negedge clk);
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    check_bit("mem_req.read_q", mem_req.read_q, 1'b0);
    check_bit("mem_req.write_q", mem_req.write_q, 1'b0);
    check_bit("cpu_rsp.read_dn", cpu_rsp.read_dn, 1'b0);
    check_bit("cpu_rsp.write_dn", cpu_rsp.write_dn, 1'b0);
    check_bit("rw_halt_out", rw_halt_out, 1'b0);
    check_bit("ext_rw_halt_out", ext_rw_halt_out, 1'b0);
    check_bit("ext_bus_allow", ext_bus_allow, 1'b0);
    check_bit("bus_busy", bus_busy, 1'b0);
    // first poll wakes the inactive pool
    na_code.raw = `CPU_NONACTIVE;
    wait_cpu_q(1'b1);
    check_sel("ext_cpu_index", ext_cpu_index, na_code);
    answer_poll(MSG_NONE);
  endtask

  task automatic test_start_msgs();
    int started;
    int n;
    started = 0;
    for (n = 0; n < 20 && started < 3; n++) begin
      if (na_next()) begin
        answer_poll(MSG_START);
        started++;
      end else begin
        answer_poll(MSG_NONE);
      end
    end
    if (started != 3) begin
      abort_run("three start messages could not be delivered");
    end
    // two full rounds over slots 0 to 2
    repeat (12) answer_poll(MSG_NONE);
  endtask

  task automatic test_end_msg();
    int n;
    for (n = 0; n < 2 && na_next(); n++) begin
      answer_poll(MSG_NONE);
    end
    answer_poll(MSG_END);
    repeat (8) answer_poll(MSG_NONE);
  endtask

  task automatic test_mem_write_read();
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
    addr = $random(seed);
    data = $random(seed);
    mem_exchange(1'b1, addr, data);
    mem_exchange(1'b0, addr, data);
  endtask

  // memory stays silent, bridge gives up
  task automatic test_mem_timeout();
    cpu_req_t req;
    mem_req_t exp_mreq;
    int       i;
    req        = '0;
    req.read_q = 1'b1;
    req.addr   = $random(seed);
    start_answer(MSG_NONE, req);
    wait_mem_req(1'b1);
    exp_mreq        = '0;
    exp_mreq.read_q = 1'b1;
    exp_mreq.addr   = req.addr;
    check_mem_req("mem_req", mem_req, exp_mreq);
    // cycle count from the rise of the request
    for (i = 1; i <= `MEM_TIMEOUT + 2; i++) begin
      @(posedge clk);
      if (i == 1) begin
        ext_cpu_e <= 1'b0;
      end
      @(negedge clk);
      check_bit("rw_halt_out", rw_halt_out, i == `MEM_TIMEOUT + 1);
      check_bit("ext_rw_halt_out", ext_rw_halt_out, i == `MEM_TIMEOUT + 1);
      check_bit("mem_req.read_q", mem_req.read_q, i <= `MEM_TIMEOUT);
      check_bit("cpu_rsp.read_dn", cpu_rsp.read_dn, 1'b0);
    end
    @(posedge clk);
    cpu_req <= '0;
    repeat (3) begin
      @(negedge clk);
      check_bit("cpu_rsp.read_dn", cpu_rsp.read_dn, 1'b0);
    end
  endtask

  task automatic test_bus_grant();
    // request lands while a poll is in flight, granted once the loop is idle
    start_answer(MSG_NONE, '0);
    ext_bus_q <= 1'b1;
    finish_answer();
    wait_bus_allow(1'b1);
    repeat (8) begin
      @(negedge clk);
      check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
      check_bit("ext_bus_allow", ext_bus_allow, 1'b1);
      check_bit("bus_busy", bus_busy, 1'b1);
    end
    @(posedge clk);
    ext_bus_q <= 1'b0;
    wait_bus_allow(1'b0);
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    // polling resumes in model order
    answer_poll(MSG_NONE);
  endtask

  initial begin
    seed       = 32'h89ba26f1;
    ext_rst_e  = 1'b1;
    ext_cpu_e  = 1'b0;
    cpu_msg_in = MSG_NONE;
    cpu_req    = '0;
    mem_rsp    = '0;
    ext_bus_q  = 1'b0;
    m_act      = 0;
    m_inact    = `CPU_QUANTITY;
    m_num      = 0;
    m_na       = 1'b0;
    test_reset_values();
    test_start_msgs();
    test_end_msg();
    test_mem_write_read();
    test_mem_timeout();
    test_bus_grant();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
